// ==== rtl/umi_pkg.sv ====
/*
 * Shared widths, command codes and packet layout for the UMI register port.
 * Only single-word (32-bit) transfers are described here. The packet keeps
 * the 256-bit UMI layout, and its upper 32 bits are reserved and sent as zero.
 * Command codes cover read request, posted write and read response only.
 */
package umi_pkg;

   // ########################################################################
   // widths
   // ########################################################################
   localparam int AW    = 32;              // address width
   localparam int DW    = 32;              // register word width
   localparam int UW    = 256;             // packet width
   localparam int NREGS = 16;              // register count
   localparam int RIW   = $clog2(NREGS);   // word index bits, from addr[2]

   typedef logic [AW-1:0] addr_t;
   typedef logic [DW-1:0] data_t;
   typedef logic [7:0]    cmd_t;
   typedef logic [3:0]    size_t;          // 0 byte, 1 half, 2+ word
   typedef logic [19:0]   opt_t;

   // ########################################################################
   // command codes
   // ########################################################################
   localparam cmd_t UMI_REQ_READ   = 8'h01;
   localparam cmd_t UMI_REQ_POSTED = 8'h05; // write, no ack
   localparam cmd_t UMI_RESP_READ  = 8'h02;

   // full packet, msb first
   typedef struct packed {
      logic [31:0]      reserved;   // zero on output
      data_t [3:0]      data;       // data[0] is the live word
      addr_t            srcaddr;
      addr_t            dstaddr;
      opt_t             options;
      size_t            size;
      cmd_t             command;
   } umi_packet_t;

   // register side strobes and fields
   typedef struct packed {
      logic  write;                 // one-cycle write strobe
      logic  read;                  // one-cycle read strobe
      cmd_t  cmd;
      size_t size;
      addr_t addr;
      data_t wrdata;
   } reg_req_t;

endpackage

// ==== rtl/umi_regif.sv ====
/*
 * UMI device port to register strobes.
 * Accepts at most one request every two cycles. A read answers one cycle
 * after acceptance, and the response is held until resp_ready.
 * Commands other than read request and posted write are taken and dropped.
 * Only the lowest data word of a request is used.
 */
`timescale 1ns/100ps

module umi_regif (
   input  logic                 clk,
   input  logic                 nreset,
   // request in
   input  logic                 req_valid,
   input  umi_pkg::umi_packet_t req_packet,
   output logic                 req_ready,
   // response out
   output logic                 resp_valid,
   output umi_pkg::umi_packet_t resp_packet,
   input  logic                 resp_ready,
   // register side
   output umi_pkg::reg_req_t    reg_req,
   input  umi_pkg::data_t       rddata
);

   logic                 accept;      // request taken this cycle
   logic                 is_read;
   logic                 is_posted;
   umi_pkg::umi_packet_t resp_next;   // response built from current request

   // ########################################################################
   // request decode
   // ########################################################################
   assign accept    = req_valid & req_ready;
   assign is_read   = (req_packet.command == umi_pkg::UMI_REQ_READ);
   assign is_posted = (req_packet.command == umi_pkg::UMI_REQ_POSTED);

   // strobes live for the acceptance cycle only
   assign reg_req.write  = accept & is_posted;
   assign reg_req.read   = accept & is_read;
   assign reg_req.cmd    = req_packet.command;
   assign reg_req.size   = req_packet.size;
   assign reg_req.addr   = req_packet.dstaddr;
   assign reg_req.wrdata = req_packet.data[0];  // single word only

   // two-cycle ready toggle
   // only rises after a cycle with resp_ready high, so a pending
   // response always drains before the next acceptance
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         req_ready <= 1'b0;
      end else begin
         req_ready <= req_valid & resp_ready & ~req_ready;
      end
   end

   // ########################################################################
   // response
   // ########################################################################
   always_comb begin
      resp_next         = '0;                      // reserved stays zero
      resp_next.command = umi_pkg::UMI_RESP_READ;
      resp_next.size    = req_packet.size;
      resp_next.options = req_packet.options;
      resp_next.dstaddr = req_packet.srcaddr;      // back to requester
      resp_next.srcaddr = req_packet.dstaddr;
      resp_next.data    = {4{rddata}};             // word in every slot
   end

   // set on read strobe, clear once host takes it
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_valid <= 1'b0;
      end else if (reg_req.read) begin
         resp_valid <= 1'b1;
      end else if (resp_ready) begin
         resp_valid <= 1'b0;
      end
   end

   // captured with the read, held until the next read
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_packet <= '0;
      end else if (reg_req.read) begin
         resp_packet <= resp_next;
      end
   end

endmodule

// ==== rtl/umi_regbank.sv ====
/*
 * Register bank of NREGS 32-bit words.
 * Word index is addr[5:2], higher address bits alias.
 * Writes are byte, half or word, with lanes chosen by addr[1:0].
 * A half ignores addr[0]. A word ignores both low bits.
 * Reads are combinational and always return the whole aligned word.
 */
`timescale 1ns/100ps

module umi_regbank (
   input  logic              clk,
   input  logic              nreset,
   input  umi_pkg::reg_req_t reg_req,
   output umi_pkg::data_t    rddata
);

   umi_pkg::data_t            regs [umi_pkg::NREGS];
   logic [umi_pkg::RIW-1:0]   idx;        // word select
   logic [1:0]                lane;       // first written lane
   logic [3:0]                lane_en;    // byte write enables
   umi_pkg::data_t            wr_lanes;   // write data moved onto lanes

   assign idx = reg_req.addr[umi_pkg::RIW+1:2];

   // ########################################################################
   // byte-lane decode
   // ########################################################################
   always_comb begin
      if (reg_req.size == 4'd0) begin          // byte
         lane    = reg_req.addr[1:0];
         lane_en = 4'b0001 << lane;
      end else if (reg_req.size == 4'd1) begin // half, even lane only
         lane    = {reg_req.addr[1], 1'b0};
         lane_en = 4'b0011 << lane;
      end else begin                            // full word
         lane    = 2'd0;
         lane_en = 4'b1111;
      end
   end

   // low bytes of wrdata slide up to the first lane
   assign wr_lanes = reg_req.wrdata << {lane, 3'b000};

   // ########################################################################
   // storage
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int r = 0; r < umi_pkg::NREGS; r++) begin
            regs[r] <= '0;
         end
      end else if (reg_req.write) begin
         for (int b = 0; b < 4; b++) begin
            if (lane_en[b]) begin
               regs[idx][8*b +: 8] <= wr_lanes[8*b +: 8];
            end
         end
      end
   end

   assign rddata = regs[idx];   // same cycle as the read strobe

endmodule

// ==== rtl/umi_reg_top.sv ====
/*
 * UMI device port in front of a sixteen-word register bank.
 * Posted writes update the bank, reads return one response packet
 * one cycle after acceptance. No other output for writes.
 */
`timescale 1ns/100ps

module umi_reg_top (
   input  logic                 clk,
   input  logic                 nreset,
   // request
   input  logic                 req_valid,
   input  umi_pkg::umi_packet_t req_packet,
   output logic                 req_ready,
   // response
   output logic                 resp_valid,
   output umi_pkg::umi_packet_t resp_packet,
   input  logic                 resp_ready
);

   umi_pkg::reg_req_t reg_req;   // strobes into the bank
   umi_pkg::data_t    rddata;    // word at reg_req.addr

   umi_regif regif (
      .clk         (clk),
      .nreset      (nreset),
      .req_valid   (req_valid),
      .req_packet  (req_packet),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_packet (resp_packet),
      .resp_ready  (resp_ready),
      .reg_req     (reg_req),
      .rddata      (rddata)
   );

   umi_regbank regbank (
      .clk     (clk),
      .nreset  (nreset),
      .reg_req (reg_req),
      .rddata  (rddata)
   );

endmodule

// ==== tb/umi_regif_asserts.sv ====
/*
 * Handshake checks bound into umi_regif.
 * All but the reset check are off while nreset is low.
 */
`timescale 1ns/100ps

module umi_regif_asserts (
   input logic                 clk,
   input logic                 nreset,
   input logic                 req_ready,
   input logic                 resp_valid,
   input logic                 resp_ready,
   input umi_pkg::umi_packet_t resp_packet,
   input umi_pkg::reg_req_t    reg_req
);

   // ready never high two cycles in a row
   a_ready_gap: assert property (@(posedge clk) disable iff (!nreset)
      req_ready |=> !req_ready)
      else $error("req_ready high for two cycles");

   // response frozen until taken
   a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_packet)))
      else $error("response changed while resp_ready low");

   // a strobe only when no response is pending
   a_one_strobe: assert property (@(posedge clk) disable iff (!nreset)
      (reg_req.write || reg_req.read) |-> !resp_valid)
      else $error("strobe while a response is pending");

   // idle in reset and on the first cycle out of it
   a_reset_idle: assert property (@(posedge clk)
      (!nreset || $rose(nreset)) |-> (!req_ready && !resp_valid))
      else $error("port not idle around reset");

endmodule

bind umi_regif umi_regif_asserts handshake_chk (.*);

// ==== tb/tb_umi_reg.sv ====
/*
 * Testbench for umi_reg_top.
 * Tests come from tb/umi_reg_tests.txt, so run it from the project root.
 * Requests go back to back; read responses are matched in order.
 * resp_ready drops at random, and a B test holds it low after acceptance.
 */
`timescale 1ns/100ps

module tb_umi_reg;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int HOLD_CYCLES  = 8;     // resp_ready low after a B read
   localparam int SEED         = 44016;

   logic                 clk;
   logic                 nreset;
   logic                 req_valid;
   umi_pkg::umi_packet_t req_packet;
   logic                 req_ready;
   logic                 resp_valid;
   umi_pkg::umi_packet_t resp_packet;
   logic                 resp_ready;
   logic                 req_hold;      // current request wants its response held

   // test table, one entry per file line
   string                t_name  [$];
   string                t_op    [$];
   umi_pkg::addr_t       t_addr  [$];
   umi_pkg::size_t       t_size  [$];
   umi_pkg::data_t       t_wdata [$];
   umi_pkg::data_t       t_exp   [$];
   int                   ntests = 0;

   // reads in flight, oldest first
   umi_pkg::umi_packet_t exp_q  [$];
   string                name_q [$];

   // monitor state
   int                   hold_left = 0;
   logic                 holding   = 1'b0;
   umi_pkg::umi_packet_t held_pkt;

   umi_reg_top uut (
      .clk         (clk),
      .nreset      (nreset),
      .req_valid   (req_valid),
      .req_packet  (req_packet),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_packet (resp_packet),
      .resp_ready  (resp_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // ########################################################################
   // helpers
   // ########################################################################
   task automatic check_value(input string name, input logic [255:0] expected,
                              input logic [255:0] actual);
      if (actual !== expected) begin
         $display("** Error: %s expected %0h actual %0h", name, expected, actual);
         $display("=== FAIL ===");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic load_tests();
      int          fd;
      int          n;
      string       name;
      string       op;
      string       rest;
      logic [31:0] addr;
      logic [31:0] size;
      logic [31:0] wdata;
      logic [31:0] expv;
      fd = $fopen("tb/umi_reg_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open tb/umi_reg_tests.txt");
         $display("=== FAIL ===");
         $fatal(1, "no test file");
      end
      while ($fscanf(fd, "%s", name) == 1) begin
         if (name[0] == "#") begin
            n = $fgets(rest, fd);   // rest of a comment line
            continue;
         end
         n = $fscanf(fd, "%s %h %h %h %h", op, addr, size, wdata, expv);
         if (n != 5) begin
            $display("malformed test line at %s", name);
            $display("=== FAIL ===");
            $fatal(1, "bad test file");
         end
         t_name.push_back(name);
         t_op.push_back(op);
         t_addr.push_back(addr);
         t_size.push_back(umi_pkg::size_t'(size));
         t_wdata.push_back(wdata);
         t_exp.push_back(expv);
      end
      $fclose(fd);
      if (t_name.size() == 0) begin
         $display("test file holds no tests");
         $display("=== FAIL ===");
         $fatal(1, "empty test file");
      end
      ntests = t_name.size();
   endtask

   // request from a table entry with random srcaddr, options and unused words
   function automatic umi_pkg::umi_packet_t make_request(input int t);
      umi_pkg::umi_packet_t p;
      p         = '0;
      p.command = (t_op[t] == "W") ? umi_pkg::UMI_REQ_POSTED : umi_pkg::UMI_REQ_READ;
      p.size    = t_size[t];
      p.dstaddr = t_addr[t];
      p.srcaddr = $urandom;
      p.options = umi_pkg::opt_t'($urandom);
      p.data[0] = t_wdata[t];
      p.data[1] = $urandom;
      p.data[2] = $urandom;
      p.data[3] = $urandom;
      return p;
   endfunction

   // read response with addresses swapped, size/options echoed, word x4
   function automatic umi_pkg::umi_packet_t expected_response(
      input umi_pkg::umi_packet_t req, input umi_pkg::data_t word);
      umi_pkg::umi_packet_t r;
      r         = '0;
      r.command = umi_pkg::UMI_RESP_READ;
      r.size    = req.size;
      r.options = req.options;
      r.dstaddr = req.srcaddr;
      r.srcaddr = req.dstaddr;
      r.data    = {word, word, word, word};
      return r;
   endfunction

   task automatic compare_response(input string name, input umi_pkg::umi_packet_t exp,
                                   input umi_pkg::umi_packet_t act);
      check_value({name, " data"}, 256'(exp.data), 256'(act.data));
      check_value({name, " command"}, 256'(exp.command), 256'(act.command));
      check_value({name, " size"}, 256'(exp.size), 256'(act.size));
      check_value({name, " options"}, 256'(exp.options), 256'(act.options));
      check_value({name, " dstaddr"}, 256'(exp.dstaddr), 256'(act.dstaddr));
      check_value({name, " srcaddr"}, 256'(exp.srcaddr), 256'(act.srcaddr));
      check_value({name, " reserved"}, 256'(exp.reserved), 256'(act.reserved));
   endtask

   // ########################################################################
   // response monitor that also drives resp_ready
   // ########################################################################
   always @(posedge clk) begin
      if (nreset) begin
         // nothing accepted while a response waits
         check_value("accept_while_busy", 256'(0),
                     256'(req_valid & req_ready & resp_valid));
         if (holding) begin
            check_value("hold resp_valid", 256'(1), 256'(resp_valid));
            check_value("hold resp_packet", 256'(held_pkt), 256'(resp_packet));
         end
         if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
               $display("response seen with no read outstanding");
               $display("=== FAIL ===");
               $fatal(1, "extra response");
            end
            compare_response(name_q.pop_front(), exp_q.pop_front(), resp_packet);
         end
         holding  = resp_valid && !resp_ready;
         held_pkt = resp_packet;
         if (req_valid && req_ready && req_hold) begin
            hold_left = HOLD_CYCLES;   // B read accepted at this edge
         end
         if (hold_left > 0) begin
            resp_ready <= 1'b0;
            hold_left--;
         end else begin
            resp_ready <= ($urandom % 3) != 0;   // low about a third
         end
      end
   end

   // ########################################################################
   // watchdog
   // ########################################################################
   initial begin
      wait (ntests > 0);
      #(CLK_PERIOD * (40 * ntests + RESET_CYCLES));
      $display("timeout: the tests did not finish in time");
      $display("=== FAIL ===");
      $fatal(1, "watchdog expired");
   end

   // ########################################################################
   // stimulus
   // ########################################################################
   initial begin
      umi_pkg::umi_packet_t pkt;
      void'($urandom(SEED));
      nreset     = 1'b0;
      req_valid  = 1'b0;
      req_packet = '0;
      req_hold   = 1'b0;
      resp_ready = 1'b0;
      load_tests();
      repeat (RESET_CYCLES) begin
         @(posedge clk);
         check_value("reset req_ready", 256'(0), 256'(req_ready));
         check_value("reset resp_valid", 256'(0), 256'(resp_valid));
      end
      nreset <= 1'b1;
      for (int t = 0; t < ntests; t++) begin
         pkt = make_request(t);
         req_packet <= pkt;
         req_valid  <= 1'b1;
         req_hold   <= (t_op[t] == "B");
         do @(posedge clk); while (!req_ready);   // accepted at this edge
         if (t_op[t] != "W") begin
            exp_q.push_back(expected_response(pkt, t_exp[t]));
            name_q.push_back(t_name[t]);
         end
      end
      req_valid <= 1'b0;
      req_hold  <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (20) @(posedge clk);   // room for a stray response
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== tb/umi_reg_tests.txt ====
# name op addr size wdata expect   (hex; op W posted write, R read, B read held)
# expect is the word a read returns, unused on writes
r00 R 00000000 2 00000000 00000000
r01 R 00000004 2 00000000 00000000
r02 R 00000008 2 00000000 00000000
r03 R 0000000c 0 00000000 00000000
r04 R 00000010 2 00000000 00000000
r05 R 00000014 1 00000000 00000000
r06 R 00000018 2 00000000 00000000
r07 R 0000001c 2 00000000 00000000
r08 R 00000020 3 00000000 00000000
r09 R 00000024 2 00000000 00000000
r10 R 00000028 2 00000000 00000000
r11 R 0000002c 2 00000000 00000000
r12 R 00000030 2 00000000 00000000
r13 R 00000034 2 00000000 00000000
r14 R 00000038 2 00000000 00000000
r15 R 0000003c 2 00000000 00000000
w_word3 W 0000000c 2 a5a5f00d 00000000
rd_word3 R 0000000c 2 00000000 a5a5f00d
w_word7 W 0000001c 2 12345678 00000000
rd_word7 R 0000001d 0 00000000 12345678
wb_lane0 W 0000000c 0 000000ee 00000000
wb_lane1 W 0000000d 0 ffffff11 00000000
rb_mid3 R 0000000c 2 00000000 a5a511ee
wb_lane2 W 0000000e 0 00000022 00000000
wb_lane3 W 0000000f 0 12345633 00000000
rb_all3 R 0000000c 2 00000000 332211ee
wh_low W 0000001d 1 ffffbeef 00000000
wh_high W 0000001e 1 0000cafe 00000000
rh_word7 R 0000001c 2 00000000 cafebeef
wh_odd W 0000001f 1 abcd0bad 00000000
rh_odd7 R 0000001c 1 00000000 0badbeef
wa_alias W 00000f24 2 deadbeef 00000000
ra_low R 00000024 2 00000000 deadbeef
ra_high R 80000064 5 00000000 deadbeef
bp_rd3 B 0000000c 2 00000000 332211ee
bp_next R 00000024 2 00000000 deadbeef
bp_rd7 B 0000001c 1 00000000 0badbeef
bp_last R 0000000f 0 00000000 332211ee

// ==== sources.f ====
rtl/umi_pkg.sv
rtl/umi_regif.sv
rtl/umi_regbank.sv
rtl/umi_reg_top.sv
tb/umi_regif_asserts.sv
tb/tb_umi_reg.sv

// ==== Makefile ====
# Verilator build and run of the UMI register port testbench

SIM := obj_dir/tb_umi_reg

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_umi_reg \
		-f sources.f -Mdir obj_dir -o tb_umi_reg
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir
